// ==== include/joypad_config.svh ====
`ifndef JOYPAD_CONFIG_SVH
`define JOYPAD_CONFIG_SVH

// System clocks per engine step
`define I2C_TICK_DIV 8'd4

// Engine steps idled after each command
`define I2C_HOLD_STEPS 5'd4

// 7-bit target address of the game controller
`define JOYPAD_ADDR 7'h52

`endif

// ==== design/joypad_pkg.sv ====
package joypad_pkg;

  typedef enum logic [1:0] {
    CMD_START = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_READ  = 2'd2,
    CMD_STOP  = 2'd3
  } i2c_cmd_e;

  // Byte engine bit-level states
  typedef enum logic [3:0] {
    E_IDLE, E_START, E_WR_SETUP, E_WR_CLK, E_RACK_SETUP_1, E_RACK_SETUP_2, E_RACK,
    E_RD_SETUP, E_RD_CLK, E_WACK_SETUP, E_WACK, E_STOP_SETUP, E_STOP, E_DELAY
  } engine_state_e;

  // Poll transaction steps
  typedef enum logic [3:0] {
    PS_IDLE, PS_START_A, PS_ADDR_W, PS_REG, PS_STOP_A,
    PS_START_B, PS_ADDR_R, PS_READ, PS_STOP_B, PS_FINISH
  } poll_state_e;

  typedef struct packed {
    i2c_cmd_e   cmd;
    logic [7:0] wdata;
    logic       mack;    // 1 = NACK after read
  } i2c_req_t;

  typedef struct packed {
    logic [7:0] rdata;
    logic       rdata_valid;
    logic       ack;     // 1 = no acknowledge
  } i2c_rsp_t;

  typedef struct packed {
    logic clk_low;
    logic dat_low;
  } bus_drive_t;

endpackage

// ==== design/i2c_phase_timer.sv ====
`timescale 1ns/1ns
`include "joypad_config.svh"

module i2c_phase_timer (
  input  logic scl,
  input  logic rst_n,
  input  logic run,
  input  logic hold_load,
  output logic step,
  output logic hold_over
);
  logic [7:0] div_cnt;
  logic [4:0] hold_cnt;

  assign step = run && (div_cnt == `I2C_TICK_DIV - 8'd1);

  // Step divider, parked at zero while the engine idles
  always_ff @(posedge scl or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= 8'd0;
    end else if (!run || step) begin
      div_cnt <= 8'd0;
    end else begin
      div_cnt <= div_cnt + 8'd1;
    end
  end

  // Hold-off after each command
  always_ff @(posedge scl or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt <= 5'd0;
    end else if (hold_load) begin
      hold_cnt <= `I2C_HOLD_STEPS;
    end else if (step && hold_cnt != 5'd0) begin
      hold_cnt <= hold_cnt - 5'd1;
    end
  end

  assign hold_over = (hold_cnt == 5'd0);

endmodule

// ==== design/i2c_shift_reg.sv ====
`timescale 1ns/1ns

module i2c_shift_reg (
  input  logic       scl,
  input  logic       rst_n,
  input  logic       load,
  input  logic [7:0] wdata,
  input  logic       shift_out,
  input  logic       shift_in,
  input  logic       in_bit,
  output logic       msb,
  output logic [7:0] byte_out,
  output logic       last_bit
);
  logic [7:0] data;
  logic [2:0] bit_cnt;

  // Shared transmit/receive byte
  always_ff @(posedge scl) begin
    if (load) begin
      data <= wdata;
    end else if (shift_out) begin
      data <= {data[6:0], data[7]};  // Rotate, MSB first
    end else if (shift_in) begin
      data <= {data[6:0], in_bit};
    end
  end

  // Bits done in the current byte
  always_ff @(posedge scl or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= 3'd0;
    end else if (load) begin
      bit_cnt <= 3'd0;
    end else if (shift_out || shift_in) begin
      bit_cnt <= bit_cnt + 3'd1;  // Wraps after eight
    end
  end

  assign msb      = data[7];
  assign byte_out = data;
  assign last_bit = (bit_cnt == 3'd7);

endmodule

// ==== design/i2c_byte_engine.sv ====
`timescale 1ns/1ns

module i2c_byte_engine (
  input  logic                   scl,
  input  logic                   rst_n,
  input  logic                   go,
  input  joypad_pkg::i2c_req_t   req,
  input  logic                   bus_dat_in,
  input  logic                   step,
  input  logic                   hold_over,
  input  logic                   msb,
  input  logic [7:0]             byte_out,
  input  logic                   last_bit,
  output joypad_pkg::i2c_rsp_t   rsp,
  output logic                   done,
  output logic                   run,
  output logic                   hold_load,
  output logic                   load,
  output logic                   shift_out,
  output logic                   shift_in,
  output logic                   in_bit,
  output joypad_pkg::bus_drive_t bus
);
  joypad_pkg::engine_state_e state, state_next;
  logic clk_low, clk_low_next;
  logic dat_low, dat_low_next;
  logic mack, mack_next;
  logic ack, ack_next;
  logic rdata_valid, rdata_valid_next;
  logic done_next;

  assign in_bit = bus_dat_in;
  assign run    = (state != joypad_pkg::E_IDLE);

  always_comb begin
    state_next       = state;
    clk_low_next     = clk_low;
    dat_low_next     = dat_low;
    mack_next        = mack;
    ack_next         = ack;
    rdata_valid_next = rdata_valid;
    done_next        = 1'b0;
    hold_load        = 1'b0;
    load             = 1'b0;
    shift_out        = 1'b0;
    shift_in         = 1'b0;

    if (state == joypad_pkg::E_IDLE) begin
      if (go) begin
        load             = 1'b1;  // Also clears the bit count
        mack_next        = req.mack;
        ack_next         = 1'b0;
        rdata_valid_next = 1'b0;
        case (req.cmd)
          joypad_pkg::CMD_START: state_next = joypad_pkg::E_START;
          joypad_pkg::CMD_WRITE: state_next = joypad_pkg::E_WR_SETUP;
          joypad_pkg::CMD_READ:  state_next = joypad_pkg::E_RD_SETUP;
          default:               state_next = joypad_pkg::E_STOP_SETUP;
        endcase
      end
    end else if (state == joypad_pkg::E_DELAY) begin
      if (hold_over) begin
        done_next  = 1'b1;
        state_next = joypad_pkg::E_IDLE;
      end
    end else if (step) begin
      case (state)
        joypad_pkg::E_START: begin
          if (!dat_low) begin
            dat_low_next = 1'b1;  // Data falls with clock high
          end else begin
            clk_low_next = 1'b1;
            hold_load    = 1'b1;
            state_next   = joypad_pkg::E_DELAY;
          end
        end
        joypad_pkg::E_WR_SETUP: begin
          dat_low_next = !msb;
          state_next   = joypad_pkg::E_WR_CLK;
        end
        joypad_pkg::E_WR_CLK: begin
          if (clk_low) begin
            clk_low_next = 1'b0;
          end else begin
            clk_low_next = 1'b1;
            shift_out    = 1'b1;
            state_next   = last_bit ? joypad_pkg::E_RACK_SETUP_1 : joypad_pkg::E_WR_SETUP;
          end
        end
        joypad_pkg::E_RACK_SETUP_1: begin
          dat_low_next = 1'b0;  // Hand data to the target
          state_next   = joypad_pkg::E_RACK_SETUP_2;
        end
        joypad_pkg::E_RACK_SETUP_2: begin
          clk_low_next = 1'b0;
          state_next   = joypad_pkg::E_RACK;
        end
        joypad_pkg::E_RACK: begin
          ack_next     = bus_dat_in;
          clk_low_next = 1'b1;
          hold_load    = 1'b1;
          state_next   = joypad_pkg::E_DELAY;
        end
        joypad_pkg::E_RD_SETUP: begin
          dat_low_next = 1'b0;
          state_next   = joypad_pkg::E_RD_CLK;
        end
        joypad_pkg::E_RD_CLK: begin
          if (clk_low) begin
            clk_low_next = 1'b0;
          end else begin
            clk_low_next = 1'b1;
            shift_in     = 1'b1;  // Sample at end of high phase
            if (last_bit) begin
              rdata_valid_next = 1'b1;
              state_next       = joypad_pkg::E_WACK_SETUP;
            end else begin
              state_next = joypad_pkg::E_RD_SETUP;
            end
          end
        end
        joypad_pkg::E_WACK_SETUP: begin
          dat_low_next = !mack;
          state_next   = joypad_pkg::E_WACK;
        end
        joypad_pkg::E_WACK: begin
          if (clk_low) begin
            clk_low_next = 1'b0;
          end else begin
            clk_low_next = 1'b1;
            hold_load    = 1'b1;
            state_next   = joypad_pkg::E_DELAY;
          end
        end
        joypad_pkg::E_STOP_SETUP: begin
          dat_low_next = 1'b1;  // Clock is low here
          state_next   = joypad_pkg::E_STOP;
        end
        joypad_pkg::E_STOP: begin
          if (clk_low) begin
            clk_low_next = 1'b0;
          end else begin
            dat_low_next = 1'b0;  // Data rises with clock high
            hold_load    = 1'b1;
            state_next   = joypad_pkg::E_DELAY;
          end
        end
        default: state_next = joypad_pkg::E_IDLE;
      endcase
    end
  end

  always_ff @(posedge scl or negedge rst_n) begin
    if (!rst_n) begin
      state       <= joypad_pkg::E_IDLE;
      clk_low     <= 1'b0;
      dat_low     <= 1'b0;
      mack        <= 1'b1;
      ack         <= 1'b0;
      rdata_valid <= 1'b0;
      done        <= 1'b0;
    end else begin
      state       <= state_next;
      clk_low     <= clk_low_next;
      dat_low     <= dat_low_next;
      mack        <= mack_next;
      ack         <= ack_next;
      rdata_valid <= rdata_valid_next;
      done        <= done_next;
    end
  end

  assign rsp = '{rdata: byte_out, rdata_valid: rdata_valid, ack: ack};
  assign bus = '{clk_low: clk_low, dat_low: dat_low};

endmodule

// ==== design/joypad_poll_seq.sv ====
`timescale 1ns/1ns
`include "joypad_config.svh"

module joypad_poll_seq (
  input  logic                 scl,
  input  logic                 rst_n,
  input  logic                 poll,
  input  logic                 done,
  input  joypad_pkg::i2c_rsp_t rsp,
  output logic                 go,
  output joypad_pkg::i2c_req_t req,
  output logic                 poll_done,
  output logic [7:0]           joypad_data,
  output logic                 nack_err
);
  joypad_pkg::poll_state_e state, next_step;
  logic waiting;     // Command issued, engine busy
  logic err;
  logic write_step;

  // Command list
  always_comb begin
    req        = '{cmd: joypad_pkg::CMD_START, wdata: 8'h00, mack: 1'b1};
    next_step  = joypad_pkg::PS_IDLE;
    write_step = 1'b0;
    case (state)
      joypad_pkg::PS_START_A: next_step = joypad_pkg::PS_ADDR_W;
      joypad_pkg::PS_ADDR_W: begin
        req.cmd    = joypad_pkg::CMD_WRITE;
        req.wdata  = {`JOYPAD_ADDR, 1'b0};
        write_step = 1'b1;
        next_step  = joypad_pkg::PS_REG;
      end
      joypad_pkg::PS_REG: begin
        req.cmd    = joypad_pkg::CMD_WRITE;  // Register 0x00
        write_step = 1'b1;
        next_step  = joypad_pkg::PS_STOP_A;
      end
      joypad_pkg::PS_STOP_A: begin
        req.cmd   = joypad_pkg::CMD_STOP;
        next_step = joypad_pkg::PS_START_B;
      end
      joypad_pkg::PS_START_B: next_step = joypad_pkg::PS_ADDR_R;
      joypad_pkg::PS_ADDR_R: begin
        req.cmd    = joypad_pkg::CMD_WRITE;
        req.wdata  = {`JOYPAD_ADDR, 1'b1};
        write_step = 1'b1;
        next_step  = joypad_pkg::PS_READ;
      end
      joypad_pkg::PS_READ: begin
        req.cmd   = joypad_pkg::CMD_READ;  // Single byte, NACK
        next_step = joypad_pkg::PS_STOP_B;
      end
      joypad_pkg::PS_STOP_B: begin
        req.cmd   = joypad_pkg::CMD_STOP;
        next_step = joypad_pkg::PS_FINISH;
      end
      default: ;
    endcase
  end

  assign go = (state != joypad_pkg::PS_IDLE) && (state != joypad_pkg::PS_FINISH) && !waiting;

  always_ff @(posedge scl or negedge rst_n) begin
    if (!rst_n) begin
      state       <= joypad_pkg::PS_IDLE;
      waiting     <= 1'b0;
      err         <= 1'b0;
      poll_done   <= 1'b0;
      nack_err    <= 1'b0;
      joypad_data <= 8'h00;
    end else begin
      poll_done <= 1'b0;
      case (state)
        joypad_pkg::PS_IDLE: begin
          if (poll) begin
            err   <= 1'b0;
            state <= joypad_pkg::PS_START_A;
          end
        end
        joypad_pkg::PS_FINISH: begin
          nack_err  <= err;
          poll_done <= 1'b1;
          state     <= joypad_pkg::PS_IDLE;
        end
        default: begin
          if (go) begin
            waiting <= 1'b1;
          end else if (done) begin
            waiting <= 1'b0;
            state   <= next_step;
            if (write_step) err <= err | rsp.ack;
            if (state == joypad_pkg::PS_READ && rsp.rdata_valid && !err) begin
              joypad_data <= rsp.rdata;  // Only from an acknowledged target
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== design/joypad_bridge.sv ====
`timescale 1ns/1ns

module joypad_bridge (
  input  logic                   scl,
  input  logic                   rst_n,
  input  logic                   poll,
  output logic                   poll_done,
  output logic [7:0]             joypad_data,
  output logic                   nack_err,
  output joypad_pkg::bus_drive_t bus,
  input  logic                   bus_dat_in
);
  joypad_pkg::i2c_req_t req;
  joypad_pkg::i2c_rsp_t rsp;
  logic go, done;
  logic run, step, hold_load, hold_over;
  logic load, shift_out, shift_in, in_bit;
  logic msb, last_bit;
  logic [7:0] byte_out;

  joypad_poll_seq u_seq (
    .scl(scl), .rst_n(rst_n), .poll(poll), .done(done), .rsp(rsp),
    .go(go), .req(req), .poll_done(poll_done),
    .joypad_data(joypad_data), .nack_err(nack_err)
  );

  i2c_byte_engine u_engine (
    .scl(scl), .rst_n(rst_n), .go(go), .req(req), .bus_dat_in(bus_dat_in),
    .step(step), .hold_over(hold_over), .msb(msb), .byte_out(byte_out),
    .last_bit(last_bit), .rsp(rsp), .done(done), .run(run), .hold_load(hold_load),
    .load(load), .shift_out(shift_out), .shift_in(shift_in), .in_bit(in_bit),
    .bus(bus)
  );

  i2c_phase_timer u_timer (
    .scl(scl), .rst_n(rst_n), .run(run), .hold_load(hold_load),
    .step(step), .hold_over(hold_over)
  );

  i2c_shift_reg u_shift (
    .scl(scl), .rst_n(rst_n), .load(load), .wdata(req.wdata),
    .shift_out(shift_out), .shift_in(shift_in), .in_bit(in_bit),
    .msb(msb), .byte_out(byte_out), .last_bit(last_bit)
  );

endmodule

// ==== tests/joypad_bridge_sva.sv ====
`timescale 1ns/1ns

module joypad_bridge_sva (
  input logic                   scl,
  input logic                   rst_n,
  input logic                   poll,
  input logic                   poll_done,
  input logic                   done,
  input logic                   bus_dat_in,
  input joypad_pkg::bus_drive_t bus
);
  logic seq_idle;

  // Tracks the sequencer from accepted poll to poll_done
  always_ff @(posedge scl or negedge rst_n) begin
    if (!rst_n) begin
      seq_idle <= 1'b1;
    end else if (poll && (seq_idle || poll_done)) begin
      seq_idle <= 1'b0;
    end else if (poll_done) begin
      seq_idle <= 1'b1;
    end
  end

  // With the clock high only the master moves data, as START or STOP
  a_dat_stable: assert property (@(posedge scl) disable iff (!rst_n)
    (!bus.clk_low && !$past(bus.clk_low) && (bus_dat_in != $past(bus_dat_in)))
      |-> (bus.dat_low != $past(bus.dat_low)))
    else $error("Data line moved while clock high outside START or STOP");

  a_done_pulse: assert property (@(posedge scl) disable iff (!rst_n) done |=> !done)
    else $error("done held for more than one cycle");

  a_poll_done_pulse: assert property (@(posedge scl) disable iff (!rst_n)
    poll_done |=> !poll_done)
    else $error("poll_done held for more than one cycle");

  a_idle_released: assert property (@(posedge scl) disable iff (!rst_n)
    seq_idle |-> (!bus.clk_low && !bus.dat_low))
    else $error("Bus lines pulled low while the sequencer is idle");

endmodule

bind joypad_bridge joypad_bridge_sva sva (
  .scl(scl), .rst_n(rst_n), .poll(poll), .poll_done(poll_done), .done(done),
  .bus_dat_in(bus_dat_in), .bus(bus)
);

// ==== tests/tb_joypad_bridge.sv ====
`timescale 1ns/1ns
`include "joypad_config.svh"

module tb_joypad_bridge;
  localparam int num_tests = 12;
  localparam int steps_per_poll = 200;  // Engine steps per poll with room to spare
  localparam int max_gap = 40;
  localparam int max_cycles = num_tests * (steps_per_poll * int'(`I2C_TICK_DIV) + max_gap) + 400;

  logic scl = 1'b0;
  logic rst_n = 1'b0;
  logic poll = 1'b0;
  logic rst_req = 1'b0;
  logic poll_req = 1'b0;
  logic poll_done;
  logic [7:0] joypad_data;
  logic nack_err;
  joypad_pkg::bus_drive_t bus;
  logic bus_dat_in;

  // Target model state
  logic tgt_low = 1'b0;
  logic tgt_next = 1'b0;
  logic present = 1'b1;
  logic [7:0] button = 8'h00;
  logic [7:0] tx = 8'h00;
  logic [7:0] shift = 8'h00;
  logic clk_prev = 1'b1;
  logic dat_prev = 1'b1;
  logic first_byte = 1'b0;
  logic read_dir = 1'b0;
  logic reading = 1'b0;
  logic addr_ok = 1'b0;
  int bit_cnt = 0;
  int starts = 0;
  int stops = 0;
  int nacks = 0;
  logic [7:0] rx_bytes[$];

  logic [31:0] lfsr = 32'h5e5f_7c5c;
  int n_pass = 0;
  int n_fail = 0;

  joypad_bridge dut (
    .scl(scl), .rst_n(rst_n), .poll(poll), .poll_done(poll_done),
    .joypad_data(joypad_data), .nack_err(nack_err), .bus(bus), .bus_dat_in(bus_dat_in)
  );

  assign bus_dat_in = !(bus.dat_low || tgt_low);  // Wired-AND with the target

  initial forever #20 scl = ~scl;

  always @(posedge scl) begin
    rst_n   <= rst_req;
    poll    <= poll_req;
    tgt_low <= tgt_next;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] r;
    r = 8'h00;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[6:0], lfsr[0]};
    end
    return r;
  endfunction

  // Bus target sampled on the falling system clock
  always @(negedge scl) begin
    logic clk_now;
    logic dat_now;
    clk_now = !bus.clk_low;
    dat_now = bus_dat_in;
    if (clk_prev && clk_now && dat_prev && !dat_now) begin
      starts++;
      bit_cnt = 0;
      first_byte = 1'b1;
      reading = 1'b0;
      addr_ok = 1'b0;
      tgt_next = 1'b0;
    end else if (clk_prev && clk_now && !dat_prev && dat_now) begin
      stops++;
      reading = 1'b0;
      tgt_next = 1'b0;
    end else if (!clk_prev && clk_now) begin
      if (bit_cnt < 8) begin
        shift = {shift[6:0], dat_now};
      end else if (reading && dat_now) begin
        nacks++;  // Master left the ack slot high
      end
      bit_cnt++;
    end else if (clk_prev && !clk_now) begin
      if (bit_cnt == 8) begin
        if (reading) begin
          tgt_next = 1'b0;
        end else begin
          rx_bytes.push_back(shift);
          if (first_byte) begin
            addr_ok = present && (shift[7:1] == 7'h52);
            read_dir = shift[0];
          end
          tgt_next = addr_ok;
        end
      end else if (bit_cnt == 9) begin
        bit_cnt = 0;
        tgt_next = 1'b0;
        if (first_byte && read_dir) begin
          reading = 1'b1;
          tx = button;
          tgt_next = addr_ok && !tx[7];
        end
        first_byte = 1'b0;
      end else if (reading && bit_cnt != 0) begin
        tx = {tx[6:0], 1'b0};
        tgt_next = addr_ok && !tx[7];
      end
    end
    clk_prev = clk_now;
    dat_prev = dat_now;
  end

  task automatic strobe_poll();
    @(negedge scl);
    poll_req = 1'b1;
    @(negedge scl);
    poll_req = 1'b0;
  endtask

  task automatic record_result(input string name, input logic ok);
    if (ok) begin
      n_pass++;
      $display("%s: passed", name);
    end else begin
      n_fail++;
      $display("%s: failed", name);
    end
  endtask

  initial begin
    logic [7:0] exp_bytes [3];
    logic [7:0] exp_data;
    logic exp_err;
    logic test_ok;
    logic extra_poll;
    string name;
    int gap;
    int base_starts;
    int base_stops;
    int base_rx;
    int base_nacks;
    exp_bytes[0] = 8'hA4;
    exp_bytes[1] = 8'h00;
    exp_bytes[2] = 8'hA5;
    exp_data = 8'h00;
    repeat (8) @(negedge scl);
    rst_req = 1'b1;

    test_ok = 1'b1;
    repeat (20) begin
      @(negedge scl);
      if (poll_done) begin
        $display("poll_done pulsed with no poll issued");
        test_ok = 1'b0;
      end
    end
    if (bus.clk_low || bus.dat_low) begin
      $display("Error reset_state bus: expected %b, actual %b", 2'b00, bus);
      test_ok = 1'b0;
    end
    if (joypad_data !== 8'h00) begin
      $display("Error reset_state: expected %h, actual %h", 8'h00, joypad_data);
      test_ok = 1'b0;
    end
    if (nack_err !== 1'b0) begin
      $display("Error reset_state: expected %b, actual %b", 1'b0, nack_err);
      test_ok = 1'b0;
    end
    record_result("reset_state", test_ok);

    for (int t = 0; t < num_tests; t++) begin
      name = $sformatf("poll_%0d", t);
      test_ok = 1'b1;
      button = take_bits(8);
      present = (take_bits(2) != 8'd0) && (t != num_tests / 2);
      extra_poll = (take_bits(1) != 8'd0);
      gap = int'(take_bits(5)) + 4;
      base_starts = starts;
      repeat (gap) @(negedge scl);
      if (starts != base_starts) begin
        $display("%s: START seen on an idle bus", name);
        test_ok = 1'b0;
      end
      base_starts = starts;
      base_stops = stops;
      base_rx = rx_bytes.size();
      base_nacks = nacks;
      strobe_poll();
      if (extra_poll) begin
        repeat (int'(take_bits(6)) + 8) @(negedge scl);
        strobe_poll();  // Lands mid-transaction
      end
      while (!poll_done) @(negedge scl);

      if (present) exp_data = button;
      exp_err = !present;
      if (nack_err !== exp_err) begin
        $display("Error %s nack_err: expected %b, actual %b", name, exp_err, nack_err);
        test_ok = 1'b0;
      end
      if (joypad_data !== exp_data) begin
        $display("Error %s data: expected %h, actual %h", name, exp_data, joypad_data);
        test_ok = 1'b0;
      end
      if (starts - base_starts != 2) begin
        $display("Error %s starts: expected 2, actual %0d", name, starts - base_starts);
        test_ok = 1'b0;
      end
      if (stops - base_stops != 2) begin
        $display("Error %s stops: expected 2, actual %0d", name, stops - base_stops);
        test_ok = 1'b0;
      end
      if (rx_bytes.size() - base_rx != 3) begin
        $display("Error %s bytes: expected 3, actual %0d", name, rx_bytes.size() - base_rx);
        test_ok = 1'b0;
      end else begin
        for (int i = 0; i < 3; i++) begin
          if (rx_bytes[base_rx + i] !== exp_bytes[i]) begin
            $display("Error %s byte %0d: expected %h, actual %h",
                     name, i, exp_bytes[i], rx_bytes[base_rx + i]);
            test_ok = 1'b0;
          end
        end
      end
      if (nacks - base_nacks != 1) begin
        $display("Error %s read nacks: expected 1, actual %0d", name, nacks - base_nacks);
        test_ok = 1'b0;
      end
      record_result(name, test_ok);
    end

    $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge scl);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing", cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
design/joypad_pkg.sv
design/i2c_phase_timer.sv
design/i2c_shift_reg.sv
design/i2c_byte_engine.sv
design/joypad_poll_seq.sv
design/joypad_bridge.sv
tests/joypad_bridge_sva.sv
tests/tb_joypad_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the joypad bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module tb_joypad_bridge \
  && ./obj_dir/Vtb_joypad_bridge > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
